// ==== list.f ====
+incdir+.
gmii_tx_pkg.sv
tx_slot_ram.sv
tx_frame_ctrl.sv
tx_fcs_gen.sv
tx_byte_mux.sv
gmii_tx_top.sv
tb_gmii_tx.sv

// ==== run.sh ====
#!/bin/sh
# build and run the GMII transmit testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_gmii_tx \
  -f list.f \
  -o tb_gmii_tx_sim \
  && ./obj_dir/tb_gmii_tx_sim \
  || { echo "simulation did not pass"; exit 1; }

exit 0

// ==== tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

typedef logic [7:0] byte_q_t[$];

// words of the frame being built, header first
logic [15:0] frame_words[$];
// wire bytes still owed by the DUT, over all pending frames
logic [7:0]  exp_bytes[$];
// gmii_tx_en high time per pending frame
int          exp_lens[$];

// msb-first crc-32 on bit-reversed input, reflected back and complemented
function automatic logic [31:0] ref_crc32(input byte_q_t data);
  logic [31:0] r;
  logic [31:0] rev;
  logic        fb;
  r = 32'hFFFF_FFFF;
  foreach (data[k]) begin
    for (int i = 0; i < 8; i++) begin
      fb = r[31] ^ data[k][i];
      r = r << 1;
      if (fb) begin
        r = r ^ 32'h04C1_1DB7;
      end
    end
  end
  for (int i = 0; i < 32; i++) begin
    rev[i] = r[31 - i];
  end
  return ~rev;
endfunction

function automatic void build_frame(input int len);
  byte_q_t     pay;
  logic [31:0] fcs;
  logic [15:0] w;
  frame_words.delete();
  frame_words.push_back({5'b0, len[10:0]});
  // timestamp and hash words, never sent
  for (int i = 1; i < `HDR_WORDS; i++) begin
    frame_words.push_back(16'($urandom));
  end
  for (int i = 0; i < len; i++) begin
    pay.push_back(8'($urandom));
  end
  for (int i = 0; i < len; i += 2) begin
    w[15:8] = pay[i];
    // odd length leaves a filler low byte that must not reach the wire
    w[7:0] = (i + 1 < len) ? pay[i + 1] : (8'($urandom) | 8'h01);
    frame_words.push_back(w);
  end
  fcs = ref_crc32(pay);
  repeat (`PREAMBLE_LEN) exp_bytes.push_back(8'h55);
  exp_bytes.push_back(8'hD5);
  foreach (pay[i]) begin
    exp_bytes.push_back(pay[i]);
  end
  for (int i = 0; i < 4; i++) begin
    exp_bytes.push_back(fcs[8 * i +: 8]);
  end
  exp_lens.push_back(len + `PREAMBLE_LEN + 1 + 4);
endfunction

`endif

// ==== tb_gmii_tx.sv ====
`timescale 1ns/10ps
`include "gmii_tx_settings.svh"

module tb_gmii_tx;

  localparam int DEPTH         = 1 << `SLOT_ADDR_W;
  localparam int FRAME_TIMEOUT = 8000;

  logic        gmii_tx_clk = 1'b0;
  logic        sys_rst;
  logic [15:0] host_wr_data;
  logic        host_wr_en;
  logic        host_commit;
  logic [7:0]  gmii_txd;
  logic        gmii_tx_en;

  string cur_test;
  int    host_ptr;
  int    frames_done;
  int    en_run;
  int    low_run;
  bit    seen_frame;

  `include "tb_frame_model.svh"

  gmii_tx_top dut (
    .gmii_tx_clk  (gmii_tx_clk),
    .sys_rst      (sys_rst),
    .host_wr_data (host_wr_data),
    .host_wr_en   (host_wr_en),
    .host_commit  (host_commit),
    .gmii_txd     (gmii_txd),
    .gmii_tx_en   (gmii_tx_en)
  );

  always #20 gmii_tx_clk = ~gmii_tx_clk;

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // wire monitor sampled mid-cycle
  always @(negedge gmii_tx_clk) begin
    logic [7:0] exp_b;
    int         exp_len;
    if (!sys_rst && gmii_tx_en) begin
      if (en_run == 0 && seen_frame) begin
        assert (low_run >= `IFG_CYCLES) else begin
          $display("Error: %s gap expected >= %0d, actual %0d", cur_test, `IFG_CYCLES, low_run);
          abort_run();
        end
      end
      assert (exp_bytes.size() > 0) else begin
        $display("%s: the DUT sent a byte while no frame was pending", cur_test);
        abort_run();
      end
      exp_b = exp_bytes.pop_front();
      assert (gmii_txd == exp_b) else begin
        $display("Error: %s byte %0d expected %h, actual %h", cur_test, en_run, exp_b, gmii_txd);
        abort_run();
      end
      en_run++;
      low_run = 0;
    end else if (!sys_rst) begin
      if (en_run != 0) begin
        exp_len = exp_lens.pop_front();
        assert (en_run == exp_len) else begin
          $display("Error: %s tx_en length expected %0d, actual %0d", cur_test, exp_len, en_run);
          abort_run();
        end
        frames_done++;
        seen_frame = 1'b1;
        en_run = 0;
      end
      low_run++;
    end
  end

  task automatic write_frame();
    foreach (frame_words[i]) begin
      @(posedge gmii_tx_clk);
      host_wr_en   <= 1'b1;
      host_wr_data <= frame_words[i];
    end
    @(posedge gmii_tx_clk);
    host_wr_en <= 1'b0;
    host_ptr = (host_ptr + frame_words.size()) % DEPTH;
  endtask

  task automatic commit_frames();
    @(posedge gmii_tx_clk);
    host_commit <= 1'b1;
    @(posedge gmii_tx_clk);
    host_commit <= 1'b0;
  endtask

  task automatic wait_frames(input int target);
    int cycles;
    cycles = 0;
    while (frames_done < target) begin
      @(posedge gmii_tx_clk);
      cycles++;
      if (cycles > FRAME_TIMEOUT) begin
        $display("%s: timed out with %0d of %0d frames seen", cur_test, frames_done, target);
        abort_run();
      end
    end
  endtask

  task automatic check_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge gmii_tx_clk);
      assert (gmii_tx_en == 1'b0 && gmii_txd == 8'h00) else begin
        $display("Error: %s en/txd expected 0/00, actual %b/%h", cur_test, gmii_tx_en, gmii_txd);
        abort_run();
      end
    end
  endtask

  // model sanity on the standard check string "123456789"
  task automatic check_model();
    byte_q_t     v;
    logic [31:0] got;
    for (int i = 0; i < 9; i++) begin
      v.push_back(8'h31 + 8'(i));
    end
    got = ref_crc32(v);
    assert (got == 32'hCBF4_3926) else begin
      $display("Error: %s crc expected cbf43926, actual %h", cur_test, got);
      abort_run();
    end
  endtask

  task automatic send_frame(input int len);
    int start;
    start = frames_done;
    build_frame(len);
    write_frame();
    commit_frames();
    wait_frames(start + 1);
  endtask

  task automatic test_reset_state();
    cur_test = "reset_state";
    check_quiet(20);
  endtask

  task automatic test_even_frame();
    cur_test = "even_frame";
    send_frame(64);
  endtask

  // the second frame only comes out right if the read pointer skipped 7 + 31 words
  task automatic test_odd_frame();
    cur_test = "odd_frame";
    send_frame(61);
    send_frame(40);
  endtask

  task automatic test_back_to_back();
    int start;
    cur_test = "back_to_back";
    start = frames_done;
    repeat (3) begin
      build_frame(20 + int'($urandom % 200));
      write_frame();
    end
    commit_frames();
    wait_frames(start + 3);
  endtask

  task automatic test_wraparound();
    bit crossed;
    int len;
    cur_test = "wraparound";
    crossed = 1'b0;
    while (!crossed) begin
      len = 1200 + int'($urandom % 315);
      build_frame(len);
      crossed = (host_ptr + frame_words.size() > DEPTH);
      write_frame();
      commit_frames();
      wait_frames(frames_done + 1);
    end
    send_frame(90);
  endtask

  task automatic test_commit_gating();
    int start;
    cur_test = "commit_gating";
    start = frames_done;
    build_frame(100);
    write_frame();
    check_quiet(50);
    commit_frames();
    wait_frames(start + 1);
  endtask

  initial begin
    sys_rst      = 1'b1;
    host_wr_data = 16'h0000;
    host_wr_en   = 1'b0;
    host_commit  = 1'b0;
    cur_test     = "model";
    host_ptr     = 0;
    frames_done  = 0;
    en_run       = 0;
    low_run      = 0;
    seen_frame   = 1'b0;
    void'($urandom(32'h8150_0c6b));
    check_model();
    repeat (5) @(posedge gmii_tx_clk);
    sys_rst <= 1'b0;
    test_reset_state();
    test_even_frame();
    test_odd_frame();
    test_back_to_back();
    test_wraparound();
    test_commit_gating();
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== gmii_tx_top.sv ====
`timescale 1ns/10ps
`include "gmii_tx_settings.svh"

module gmii_tx_top (
  input  logic        gmii_tx_clk,
  input  logic        sys_rst,
  input  logic [15:0] host_wr_data,
  input  logic        host_wr_en,
  input  logic        host_commit,
  output logic [7:0]  gmii_txd,
  output logic        gmii_tx_en
);

  logic [`SLOT_ADDR_W-1:0] rd_addr;
  logic [`SLOT_ADDR_W-1:0] commit_ptr;
  logic [15:0]             rd_data;
  gmii_tx_pkg::byte_src_e  byte_src;
  logic                    word_load;
  logic                    crc_init;
  logic                    crc_en;
  logic [1:0]              fcs_idx;
  logic [7:0]              next_byte;
  logic [7:0]              fcs_byte;

  tx_slot_ram u_slot_ram (
    .gmii_tx_clk  (gmii_tx_clk),
    .sys_rst      (sys_rst),
    .host_wr_data (host_wr_data),
    .host_wr_en   (host_wr_en),
    .host_commit  (host_commit),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .commit_ptr   (commit_ptr)
  );

  tx_frame_ctrl u_frame_ctrl (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .commit_ptr  (commit_ptr),
    .rd_data     (rd_data),
    .rd_addr     (rd_addr),
    .byte_src    (byte_src),
    .word_load   (word_load),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .fcs_idx     (fcs_idx)
  );

  tx_byte_mux u_byte_mux (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .byte_src    (byte_src),
    .word_load   (word_load),
    .rd_data     (rd_data),
    .fcs_byte    (fcs_byte),
    .next_byte   (next_byte),
    .gmii_txd    (gmii_txd),
    .gmii_tx_en  (gmii_tx_en)
  );

  tx_fcs_gen u_fcs_gen (
    .gmii_tx_clk (gmii_tx_clk),
    .sys_rst     (sys_rst),
    .crc_init    (crc_init),
    .crc_en      (crc_en),
    .next_byte   (next_byte),
    .fcs_idx     (fcs_idx),
    .fcs_byte    (fcs_byte)
  );

endmodule

// ==== tx_byte_mux.sv ====
`timescale 1ns/10ps

module tx_byte_mux (
  input  logic                   gmii_tx_clk,
  input  logic                   sys_rst,
  input  gmii_tx_pkg::byte_src_e byte_src,
  input  logic                   word_load,
  input  logic [15:0]            rd_data,
  input  logic [7:0]             fcs_byte,
  output logic [7:0]             next_byte,
  output logic [7:0]             gmii_txd,
  output logic                   gmii_tx_en
);

  gmii_tx_pkg::slot_word_u cur_word;

  // current payload word, held across its two bytes
  always_ff @(posedge gmii_tx_clk) begin
    if (word_load) begin
      cur_word <= gmii_tx_pkg::slot_word_u'(rd_data);
    end
  end

  always_comb begin
    case (byte_src)
      gmii_tx_pkg::src_preamble: next_byte = 8'h55;
      gmii_tx_pkg::src_sfd:      next_byte = 8'hD5;
      gmii_tx_pkg::src_pay_hi:   next_byte = cur_word.pay.byte_hi;
      gmii_tx_pkg::src_pay_lo:   next_byte = cur_word.pay.byte_lo;
      gmii_tx_pkg::src_fcs:      next_byte = fcs_byte;
      default:                   next_byte = 8'h00;
    endcase
  end

  // output register, one cycle behind byte_src
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      gmii_txd   <= 8'h00;
      gmii_tx_en <= 1'b0;
    end else begin
      gmii_txd   <= next_byte;
      gmii_tx_en <= (byte_src != gmii_tx_pkg::src_none);
    end
  end

endmodule

// ==== tx_fcs_gen.sv ====
`timescale 1ns/10ps

module tx_fcs_gen (
  input  logic       gmii_tx_clk,
  input  logic       sys_rst,
  input  logic       crc_init,
  input  logic       crc_en,
  input  logic [7:0] next_byte,
  input  logic [1:0] fcs_idx,
  output logic [7:0] fcs_byte
);

  logic [31:0] crc;
  logic [31:0] crc_inv;

  // reflected crc-32 over one byte lsb first
  function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c;
    for (int i = 0; i < 8; i++) begin
      if (r[0] ^ d[i]) begin
        r = (r >> 1) ^ 32'hEDB8_8320;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      crc <= '1;
    end else if (crc_init) begin
      crc <= '1;
    end else if (crc_en) begin
      crc <= crc32_byte(crc, next_byte);
    end
  end

  // final complement with the lowest byte out first
  assign crc_inv  = ~crc;
  assign fcs_byte = crc_inv[{fcs_idx, 3'b000} +: 8];

endmodule

// ==== tx_frame_ctrl.sv ====
`timescale 1ns/10ps
`include "gmii_tx_settings.svh"

module tx_frame_ctrl (
  input  logic                    gmii_tx_clk,
  input  logic                    sys_rst,
  input  logic [`SLOT_ADDR_W-1:0] commit_ptr,
  input  logic [15:0]             rd_data,
  output logic [`SLOT_ADDR_W-1:0] rd_addr,
  output gmii_tx_pkg::byte_src_e  byte_src,
  output logic                    word_load,
  output logic                    crc_init,
  output logic                    crc_en,
  output logic [1:0]              fcs_idx
);

  gmii_tx_pkg::tx_state_e  state;
  gmii_tx_pkg::slot_word_u hdr_word;
  logic [10:0]             cnt;
  logic [10:0]             frame_len;
  logic [`SLOT_ADDR_W-1:0] rd_ptr;
  logic                    frame_pending;
  logic                    sfd_cycle;
  logic                    last_pay;
  logic                    rd_adv;

  assign hdr_word      = gmii_tx_pkg::slot_word_u'(rd_data);
  assign rd_addr       = rd_ptr;
  assign frame_pending = (commit_ptr != rd_ptr);
  assign sfd_cycle     = (state == gmii_tx_pkg::tx_preamble) &&
                         (cnt == 11'(`PREAMBLE_LEN));
  assign last_pay      = (cnt == frame_len - 11'd1);

  // first payload word is latched on the SFD cycle,
  // each later one on the low byte of the word before it
  assign word_load = sfd_cycle ||
                     ((state == gmii_tx_pkg::tx_payload) && cnt[0] && !last_pay);

  // read pointer runs one word ahead of the byte mux
  always_comb begin
    rd_adv = word_load;
    if ((state == gmii_tx_pkg::tx_idle) && frame_pending) begin
      rd_adv = 1'b1;
    end
    if ((state == gmii_tx_pkg::tx_preamble) && (cnt < 11'(`HDR_WORDS - 1))) begin
      rd_adv = 1'b1;
    end
  end

  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      state     <= gmii_tx_pkg::tx_idle;
      cnt       <= '0;
      frame_len <= '0;
      rd_ptr    <= '0;
    end else begin
      if (rd_adv) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case (state)
        gmii_tx_pkg::tx_idle: begin
          cnt <= '0;
          if (frame_pending) begin
            state <= gmii_tx_pkg::tx_preamble;
          end
        end
        gmii_tx_pkg::tx_preamble: begin
          cnt <= cnt + 11'd1;
          // header word 0 arrives on the first preamble cycle
          if (cnt == 11'd0) begin
            frame_len <= hdr_word.hdr.frame_len;
          end
          if (sfd_cycle) begin
            state <= gmii_tx_pkg::tx_payload;
            cnt   <= '0;
          end
        end
        gmii_tx_pkg::tx_payload: begin
          cnt <= cnt + 11'd1;
          if (last_pay) begin
            state <= gmii_tx_pkg::tx_fcs;
            cnt   <= '0;
          end
        end
        gmii_tx_pkg::tx_fcs: begin
          cnt <= cnt + 11'd1;
          if (cnt == 11'd3) begin
            state <= gmii_tx_pkg::tx_gap;
            cnt   <= '0;
          end
        end
        gmii_tx_pkg::tx_gap: begin
          cnt <= cnt + 11'd1;
          if (cnt == 11'(`IFG_CYCLES - 1)) begin
            state <= gmii_tx_pkg::tx_idle;
            cnt   <= '0;
          end
        end
        default: begin
          state <= gmii_tx_pkg::tx_idle;
        end
      endcase
    end
  end

  // byte source per state
  always_comb begin
    byte_src = gmii_tx_pkg::src_none;
    case (state)
      gmii_tx_pkg::tx_preamble: begin
        if (sfd_cycle) begin
          byte_src = gmii_tx_pkg::src_sfd;
        end else begin
          byte_src = gmii_tx_pkg::src_preamble;
        end
      end
      gmii_tx_pkg::tx_payload: begin
        // high byte on even counts
        if (cnt[0]) begin
          byte_src = gmii_tx_pkg::src_pay_lo;
        end else begin
          byte_src = gmii_tx_pkg::src_pay_hi;
        end
      end
      gmii_tx_pkg::tx_fcs: begin
        byte_src = gmii_tx_pkg::src_fcs;
      end
      default: begin
        byte_src = gmii_tx_pkg::src_none;
      end
    endcase
  end

  assign crc_init = (state == gmii_tx_pkg::tx_preamble);
  assign crc_en   = (state == gmii_tx_pkg::tx_payload);
  assign fcs_idx  = cnt[1:0];

  // length taken from header word 0 must be sendable
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    ((state == gmii_tx_pkg::tx_preamble) && (cnt == 11'd1)) |->
      ((frame_len != 11'd0) && (frame_len <= 11'(`MAX_FRAME_LEN))))
    else $error("bad frame length %0d", frame_len);

endmodule

// ==== tx_slot_ram.sv ====
`timescale 1ns/10ps
`include "gmii_tx_settings.svh"

module tx_slot_ram (
  input  logic                    gmii_tx_clk,
  input  logic                    sys_rst,
  input  logic [15:0]             host_wr_data,
  input  logic                    host_wr_en,
  input  logic                    host_commit,
  input  logic [`SLOT_ADDR_W-1:0] rd_addr,
  output logic [15:0]             rd_data,
  output logic [`SLOT_ADDR_W-1:0] commit_ptr
);

  logic [15:0] mem [0:(1 << `SLOT_ADDR_W)-1];
  logic [`SLOT_ADDR_W-1:0] fill_ptr;

  // host write port and registered read port
  always_ff @(posedge gmii_tx_clk) begin
    if (host_wr_en) begin
      mem[fill_ptr] <= host_wr_data;
    end
    rd_data <= mem[rd_addr];
  end

  // fill pointer wraps at the end of the memory
  always_ff @(posedge gmii_tx_clk) begin
    if (sys_rst) begin
      fill_ptr   <= '0;
      commit_ptr <= '0;
    end else begin
      if (host_wr_en) begin
        fill_ptr <= fill_ptr + 1'b1;
      end
      // a word written with the commit pulse is part of the frame
      if (host_commit) begin
        if (host_wr_en) begin
          commit_ptr <= fill_ptr + 1'b1;
        end else begin
          commit_ptr <= fill_ptr;
        end
      end
    end
  end

  // host must not overrun words the sender still has to read
  assert property (@(posedge gmii_tx_clk) disable iff (sys_rst)
    (host_wr_en && (commit_ptr != rd_addr)) |-> (fill_ptr != rd_addr))
    else $error("slot ram overrun at address %0d", fill_ptr);

endmodule

// ==== gmii_tx_pkg.sv ====
package gmii_tx_pkg;

  // controller states
  typedef enum logic [2:0] {
    tx_idle     = 3'd0,
    tx_preamble = 3'd1,
    tx_payload  = 3'd2,
    tx_fcs      = 3'd3,
    tx_gap      = 3'd4
  } tx_state_e;

  // where the next wire byte comes from
  typedef enum logic [2:0] {
    src_none     = 3'd0,
    src_preamble = 3'd1,
    src_sfd      = 3'd2,
    src_pay_hi   = 3'd3,
    src_pay_lo   = 3'd4,
    src_fcs      = 3'd5
  } byte_src_e;

  // one slot word, read as payload bytes or as the length header
  typedef union packed {
    struct packed {
      logic [7:0] byte_hi;
      logic [7:0] byte_lo;
    } pay;
    struct packed {
      logic [4:0]  rsvd;
      logic [10:0] frame_len;
    } hdr;
  } slot_word_u;

endpackage

// ==== gmii_tx_settings.svh ====
`ifndef GMII_TX_SETTINGS_SVH
`define GMII_TX_SETTINGS_SVH

// slot memory address width, 16384 words
`define SLOT_ADDR_W 14

// header words ahead of each payload
// word 0 is the length, the rest is metadata
`define HDR_WORDS 7

// 0x55 bytes before the SFD
`define PREAMBLE_LEN 7

// idle cycles between frames
`define IFG_CYCLES 12

// largest payload in bytes
`define MAX_FRAME_LEN 1514

`endif
